// ==== Makefile ====
TOP = cart_mapper_tb
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove build output and log"

test:
	verilator --binary --assert --timing -f sources.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then exit 1; fi
	@grep -q "Test passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== sources.f ====
src/snes_bus_pkg.sv
src/cart_map_pkg.sv
src/map_config.sv
src/peripheral_decode.sv
src/address.sv
src/bus_cycle_capture.sv
src/cart_mapper_top.sv
testbench/cart_mapper_checks.sv
testbench/cart_mapper_tb.sv

// ==== src/address.sv ====
module address (
  input  logic                       CLK,
  input  logic                       rst,
  input  cart_map_pkg::map_cfg_t     cfg,
  input  snes_bus_pkg::snes_addr_t   snes_addr,
  input  snes_bus_pkg::periph_addr_t snes_pa,
  input  logic                       snes_romsel,
  output snes_bus_pkg::mem_req_t     map_req,  // Address and flag fields
  output snes_bus_pkg::mem_req_t     enables   // Peripheral enable fields
);

  logic [7:0]               mapper_onehot;
  logic                     hi_layout;    // HiROM and ExHiROM share save-RAM rules
  logic                     sram_window;
  logic                     is_patch;
  logic                     is_saveram;
  logic                     is_rom;
  snes_bus_pkg::sram_addr_t hi_sav_addr;
  snes_bus_pkg::sram_addr_t lo_sav_addr;
  snes_bus_pkg::sram_addr_t sram_addr;

  // Registered mapper decode, so the wide compare is off the bus path
  always_ff @(posedge CLK) begin
    if (rst) begin
      mapper_onehot <= 8'b1000_0000; // Menu mapper
    end else begin
      for (int i = 0; i < 8; i++) begin
        mapper_onehot[i] <= (cfg.mapper == 3'(i));
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Save-RAM and patch qualification
  //////////////////////////////////////////////////////////////////////

  assign hi_layout = mapper_onehot[cart_map_pkg::MAP_HIROM]
                   | mapper_onehot[cart_map_pkg::MAP_EXHIROM];

  always_comb begin
    sram_window = 1'b0;
    if (hi_layout) begin
      // Banks 20-3F/A0-BF, offset 6000-7FFF
      sram_window = ~snes_addr[22] & snes_addr[21] & ~snes_addr[15]
                  & snes_addr[14] & snes_addr[13];
    end else if (mapper_onehot[cart_map_pkg::MAP_LOROM]) begin
      // Banks 70-7F/F0-FF, upper half only kept for small ROMs
      sram_window = (&snes_addr[22:20]) & ~snes_romsel
                  & (~snes_addr[15] | ~cfg.rom_mask[21]);
    end else if (mapper_onehot[cart_map_pkg::MAP_MENU]) begin
      sram_window = &snes_addr[23:20]; // Whole banks F0-FF
    end
  end

  assign is_saveram = cfg.saveram_mask[0] & ~cfg.map_unlock & sram_window;
  assign is_patch   = cfg.map_unlock & snes_addr[23] & snes_addr[22];
  assign is_rom     = snes_addr[22] | snes_addr[15];

  //////////////////////////////////////////////////////////////////////
  // SRAM address translation
  //////////////////////////////////////////////////////////////////////

  assign hi_sav_addr = 24'hE00000
                     + ({6'b0, snes_addr[20:16], snes_addr[12:0]} & cfg.saveram_mask);
  assign lo_sav_addr = 24'hE00000
                     + ({4'b0, snes_addr[20:16], snes_addr[14:0]} & cfg.saveram_mask);

  always_comb begin
    sram_addr = '0; // Unused mapper codes
    if (is_patch) begin
      sram_addr = snes_addr;
    end else if (mapper_onehot[cart_map_pkg::MAP_HIROM]) begin
      sram_addr = is_saveram ? hi_sav_addr
                             : ({1'b0, snes_addr[22:0]} & cfg.rom_mask);
    end else if (mapper_onehot[cart_map_pkg::MAP_LOROM]) begin
      sram_addr = is_saveram ? lo_sav_addr
                             : ({1'b0, ~snes_addr[23], snes_addr[22:16], snes_addr[14:0]}
                                & cfg.rom_mask);
    end else if (mapper_onehot[cart_map_pkg::MAP_EXHIROM]) begin
      sram_addr = is_saveram ? hi_sav_addr
                             : ({1'b0, ~snes_addr[23], snes_addr[21:0]} & cfg.rom_mask);
    end else if (mapper_onehot[cart_map_pkg::MAP_MENU]) begin
      // Menu image sits at C00000 in SRAM
      sram_addr = is_saveram ? snes_addr
                             : (({1'b0, snes_addr[22:0]} & cfg.rom_mask) + 24'hC00000);
    end
  end

  always_comb begin
    map_req             = '0;
    map_req.sram_addr   = sram_addr;
    map_req.is_saveram  = is_saveram;
    map_req.is_rom      = is_rom;
    map_req.is_writable = is_saveram | is_patch;
    map_req.rom_hit     = is_rom | is_saveram | is_patch;
  end

  peripheral_decode u_periph (
    .cfg           (cfg),
    .mapper_onehot (mapper_onehot),
    .snes_addr     (snes_addr),
    .snes_pa       (snes_pa),
    .enables       (enables)
  );

endmodule

// ==== src/bus_cycle_capture.sv ====
module bus_cycle_capture (
  input  logic                   CLK,
  input  logic                   rst,
  input  logic                   cycle_start,
  input  snes_bus_pkg::mem_req_t map_req,  // Address and flags valid here
  input  snes_bus_pkg::mem_req_t enables,  // Enables valid here
  output snes_bus_pkg::mem_req_t req,
  output logic                   req_valid
);

  snes_bus_pkg::mem_req_t merged;

  //////////////////////////////////////////////////////////////////////
  // Merge the two halves of the decode
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    merged             = enables;
    merged.sram_addr   = map_req.sram_addr;
    merged.rom_hit     = map_req.rom_hit;
    merged.is_saveram  = map_req.is_saveram;
    merged.is_rom      = map_req.is_rom;
    merged.is_writable = map_req.is_writable;
  end

  // Request payload, held until the next strobe
  always_ff @(posedge CLK) begin
    if (cycle_start) begin
      req <= merged;
    end
  end

  // One pulse per strobe
  always_ff @(posedge CLK) begin
    if (rst) begin
      req_valid <= 1'b0;
    end else begin
      req_valid <= cycle_start;
    end
  end

endmodule

// ==== src/cart_map_pkg.sv ====
package cart_map_pkg;

  // Mapper codes as set by the MCU
  typedef logic [2:0] mapper_code_t;

  localparam mapper_code_t MAP_HIROM   = 3'd0;
  localparam mapper_code_t MAP_LOROM   = 3'd1;
  localparam mapper_code_t MAP_EXHIROM = 3'd2;
  localparam mapper_code_t MAP_MENU    = 3'd7;

  // Feature word and bit positions
  typedef logic [15:0] feature_bits_t;

  localparam int FEAT_DSPX = 0;
  localparam int FEAT_SRTC = 2;
  localparam int FEAT_MSU1 = 3;
  localparam int FEAT_213F = 4;
  localparam int FEAT_DMA1 = 7;

  typedef logic [23:0] addr_mask_t; // ROM and save-RAM size masks

  // Config register selectors
  typedef logic [2:0] cfg_sel_t;

  localparam cfg_sel_t CFG_MAPPER       = 3'd0;
  localparam cfg_sel_t CFG_FEATURES     = 3'd1;
  localparam cfg_sel_t CFG_ROM_MASK     = 3'd2;
  localparam cfg_sel_t CFG_SAVERAM_MASK = 3'd3;
  localparam cfg_sel_t CFG_UNLOCK       = 3'd4;

  typedef struct packed {
    mapper_code_t  mapper;
    feature_bits_t features;
    addr_mask_t    rom_mask;
    addr_mask_t    saveram_mask;
    logic          map_unlock; // Patch window open, save-RAM off
  } map_cfg_t;

endpackage

// ==== src/cart_mapper_top.sv ====
module cart_mapper_top (
  input  logic                       CLK,
  input  logic                       rst,
  // MCU configuration port
  input  logic                       cfg_write,
  input  cart_map_pkg::cfg_sel_t     cfg_sel,
  input  logic [23:0]                cfg_data,
  // Console bus
  input  logic                       cycle_start,
  input  snes_bus_pkg::snes_addr_t   snes_addr,
  input  snes_bus_pkg::periph_addr_t snes_pa,
  input  logic                       snes_romsel,
  // To the SRAM controller and peripherals
  output snes_bus_pkg::mem_req_t     req,
  output logic                       req_valid
);

  cart_map_pkg::map_cfg_t cfg;
  snes_bus_pkg::mem_req_t map_req;
  snes_bus_pkg::mem_req_t enables;

  map_config u_config (
    .CLK       (CLK),
    .rst       (rst),
    .cfg_write (cfg_write),
    .cfg_sel   (cfg_sel),
    .cfg_data  (cfg_data),
    .cfg       (cfg)
  );

  address u_address (
    .CLK         (CLK),
    .rst         (rst),
    .cfg         (cfg),
    .snes_addr   (snes_addr),
    .snes_pa     (snes_pa),
    .snes_romsel (snes_romsel),
    .map_req     (map_req),
    .enables     (enables)
  );

  bus_cycle_capture u_capture (
    .CLK         (CLK),
    .rst         (rst),
    .cycle_start (cycle_start),
    .map_req     (map_req),
    .enables     (enables),
    .req         (req),
    .req_valid   (req_valid)
  );

endmodule

// ==== src/map_config.sv ====
module map_config (
  input  logic                   CLK,
  input  logic                   rst,
  input  logic                   cfg_write,
  input  cart_map_pkg::cfg_sel_t cfg_sel,
  input  logic [23:0]            cfg_data,
  output cart_map_pkg::map_cfg_t cfg
);

  //////////////////////////////////////////////////////////////////////
  // MCU-written registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (rst) begin
      cfg.mapper       <= cart_map_pkg::MAP_MENU; // Boot into the menu
      cfg.features     <= '0;
      cfg.rom_mask     <= '1;
      cfg.saveram_mask <= '0;
      cfg.map_unlock   <= 1'b0;
    end else if (cfg_write) begin
      case (cfg_sel)
        cart_map_pkg::CFG_MAPPER: begin
          cfg.mapper <= cfg_data[2:0];
        end
        cart_map_pkg::CFG_FEATURES: begin
          cfg.features <= cfg_data[15:0];
        end
        cart_map_pkg::CFG_ROM_MASK: begin
          cfg.rom_mask <= cfg_data;
        end
        cart_map_pkg::CFG_SAVERAM_MASK: begin
          cfg.saveram_mask <= cfg_data;
        end
        cart_map_pkg::CFG_UNLOCK: begin
          cfg.map_unlock <= cfg_data[0];
        end
        default: begin
          // Unknown selector, write ignored
        end
      endcase
    end
  end

endmodule

// ==== src/peripheral_decode.sv ====
module peripheral_decode (
  input  cart_map_pkg::map_cfg_t     cfg,
  input  logic [7:0]                 mapper_onehot,
  input  snes_bus_pkg::snes_addr_t   snes_addr,
  input  snes_bus_pkg::periph_addr_t snes_pa,
  output snes_bus_pkg::mem_req_t     enables
);

  logic        sys_bank; // Banks 00-3F/80-BF, where the $2xxx I/O lives
  logic [15:0] offs;
  logic        is_lorom;
  logic        is_hirom;
  logic        dspx_win;

  assign sys_bank = ~snes_addr[22];
  assign offs     = snes_addr[15:0];
  assign is_lorom = mapper_onehot[cart_map_pkg::MAP_LOROM];
  assign is_hirom = mapper_onehot[cart_map_pkg::MAP_HIROM];

  // Coprocessor data/status windows
  always_comb begin
    dspx_win = 1'b0;
    if (is_lorom && cfg.rom_mask[20]) begin
      dspx_win = snes_addr[22] & snes_addr[21] & ~snes_addr[20] & ~snes_addr[15]; // 60-6F
    end else if (is_lorom) begin
      dspx_win = ~snes_addr[22] & snes_addr[21] & snes_addr[20] & snes_addr[15]; // 30-3F
    end else if (is_hirom) begin
      dspx_win = ~snes_addr[22] & ~snes_addr[21] & ~snes_addr[20] & ~snes_addr[15]
               & snes_addr[14] & snes_addr[13];
    end
  end

  always_comb begin
    enables = '0;

    enables.msu  = cfg.features[cart_map_pkg::FEAT_MSU1] & sys_bank
                 & (offs[15:3] == 13'h0400);                // 2000-2007
    enables.dma  = (cfg.features[cart_map_pkg::FEAT_DMA1] | cfg.map_unlock) & sys_bank
                 & (offs[15:4] == 12'h202);                 // 2020-202F
    enables.srtc = cfg.features[cart_map_pkg::FEAT_SRTC] & sys_bank
                 & (offs[15:1] == 15'h1400);                // 2800-2801
    enables.exe  = sys_bank & (offs == 16'h2C00);

    // Command area 2A00-2FFF
    enables.snescmd = sys_bank & (offs[15:11] == 5'b00101) & (offs[10:9] != 2'b00);
    enables.nmicmd  = (snes_addr == 24'h002BF2);

    // B-bus hits
    enables.r213f = cfg.features[cart_map_pkg::FEAT_213F] & (snes_pa == 8'h3F);
    enables.r2100 = (snes_pa == 8'h00);

    enables.dspx    = cfg.features[cart_map_pkg::FEAT_DSPX] & dspx_win;
    enables.dspx_a0 = 1'b1;
    if (cfg.features[cart_map_pkg::FEAT_DSPX]) begin
      if (is_lorom) begin
        enables.dspx_a0 = snes_addr[14];
      end else if (is_hirom) begin
        enables.dspx_a0 = snes_addr[12];
      end
    end
  end

endmodule

// ==== src/snes_bus_pkg.sv ====
package snes_bus_pkg;

  //////////////////////////////////////////////////////////////////////
  // Console bus widths
  //////////////////////////////////////////////////////////////////////

  typedef logic [23:0] snes_addr_t;   // A-bus, bank and offset
  typedef logic [7:0]  periph_addr_t; // B-bus, low byte of $21xx
  typedef logic [23:0] sram_addr_t;   // External SRAM byte address

  //////////////////////////////////////////////////////////////////////
  // One memory request per bus cycle
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    sram_addr_t sram_addr;
    // Memory qualification
    logic       rom_hit;     // SRAM access needed at all
    logic       is_saveram;
    logic       is_rom;
    logic       is_writable;
    // Peripheral enables
    logic       msu;
    logic       dma;
    logic       srtc;
    logic       exe;
    logic       dspx;
    logic       dspx_a0;     // Data/status select for the coprocessor
    logic       r213f;
    logic       r2100;
    logic       snescmd;
    logic       nmicmd;
  } mem_req_t;

endpackage

// ==== testbench/cart_mapper_checks.sv ====
module cart_mapper_checks (
  input logic                   CLK,
  input logic                   rst,
  input logic                   cycle_start,
  input snes_bus_pkg::mem_req_t req,
  input logic                   req_valid
);

  timeunit 1ns;
  timeprecision 1ps;

  snes_bus_pkg::mem_req_t expected[$]; // One entry per issued bus cycle
  snes_bus_pkg::mem_req_t exp_req;
  logic                   strobe_d = 1'b0; // Strobe seen on the previous edge
  int                     error_count = 0;

  task automatic expect_req(input snes_bus_pkg::mem_req_t r);
    expected.push_back(r);
  endtask

  function automatic int pending();
    return expected.size();
  endfunction

  task automatic compare_field(input string name, input logic [23:0] exp,
                               input logic [23:0] act);
    assert (act === exp) else begin
      $display("CHECK FAILED at %0t: %s expected %0h got %0h", $time, name, exp, act);
      error_count++;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Compare every request against the oldest expected one
  //////////////////////////////////////////////////////////////////////

  always @(posedge CLK) begin
    strobe_d <= cycle_start;
    // req_valid is due exactly one cycle after each strobe
    if (!rst) begin
      compare_field("req_valid", strobe_d, req_valid);
    end
    if (!rst && req_valid) begin
      if (expected.size() == 0) begin
        $display("Error at %0t: req_valid pulsed with no bus cycle outstanding", $time);
        error_count++;
      end else begin
        exp_req = expected.pop_front();
        compare_field("sram_addr", exp_req.sram_addr, req.sram_addr);
        compare_field("rom_hit", exp_req.rom_hit, req.rom_hit);
        compare_field("is_saveram", exp_req.is_saveram, req.is_saveram);
        compare_field("is_rom", exp_req.is_rom, req.is_rom);
        compare_field("is_writable", exp_req.is_writable, req.is_writable);
        compare_field("msu", exp_req.msu, req.msu);
        compare_field("dma", exp_req.dma, req.dma);
        compare_field("srtc", exp_req.srtc, req.srtc);
        compare_field("exe", exp_req.exe, req.exe);
        compare_field("dspx", exp_req.dspx, req.dspx);
        compare_field("dspx_a0", exp_req.dspx_a0, req.dspx_a0);
        compare_field("r213f", exp_req.r213f, req.r213f);
        compare_field("r2100", exp_req.r2100, req.r2100);
        compare_field("snescmd", exp_req.snescmd, req.snescmd);
        compare_field("nmicmd", exp_req.nmicmd, req.nmicmd);
      end
    end
  end

endmodule

// ==== testbench/cart_mapper_tb.sv ====
module cart_mapper_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int ISSUES     = 28 + 3 * 4 * 16 + 18 + 4 * 40 + 6 * 8;
  localparam int CFG_CYCLES = 2 * 61 + 8;
  localparam int MAX_CYCLES = 4 * (ISSUES + CFG_CYCLES);

  logic                       CLK;
  logic                       rst;
  logic                       cfg_write;
  cart_map_pkg::cfg_sel_t     cfg_sel;
  logic [23:0]                cfg_data;
  logic                       cycle_start;
  snes_bus_pkg::snes_addr_t   snes_addr;
  snes_bus_pkg::periph_addr_t snes_pa;
  logic                       snes_romsel;
  snes_bus_pkg::mem_req_t     req;
  logic                       req_valid;

  // Model copy of the configuration
  logic [2:0]  m_mapper = 3'd7;
  logic [15:0] m_feat   = '0;
  logic [23:0] m_rom    = '1;
  logic [23:0] m_sav    = '0;
  logic        m_unlock = 1'b0;
  int          cycles   = 0;
  logic [15:0] edges[20] = '{16'h1FFF, 16'h2000, 16'h2007, 16'h2008, 16'h201F, 16'h2020,
                             16'h202F, 16'h2030, 16'h27FF, 16'h2800, 16'h2801, 16'h2802,
                             16'h29FF, 16'h2A00, 16'h2BF2, 16'h2BFF, 16'h2C00, 16'h2C01,
                             16'h2FFF, 16'h3000};

  cart_mapper_top uut (.*);

  cart_mapper_checks u_checks (
    .CLK         (CLK),
    .rst         (rst),
    .cycle_start (cycle_start),
    .req         (req),
    .req_valid   (req_valid)
  );

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  always @(posedge CLK) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("Test failed");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Reference model of the mapping and peripheral rules
  //////////////////////////////////////////////////////////////////////

  function automatic snes_bus_pkg::mem_req_t model(input logic [23:0] a,
                                                   input logic [7:0] pa, input logic romsel);
    snes_bus_pkg::mem_req_t r;
    logic        win;
    logic        patch;
    logic        sav;
    logic        dwin;
    logic [15:0] off;
    r     = '0;
    win   = 1'b0;
    dwin  = 1'b0;
    off   = a[15:0];
    patch = m_unlock & a[23] & a[22];
    case (m_mapper)
      3'd0, 3'd2: win = !a[22] && a[21] && !a[15] && a[14] && a[13];
      3'd1:       win = a[22:20] == 3'b111 && !romsel && (!a[15] || !m_rom[21]);
      3'd7:       win = a[23:20] == 4'hF;
      default:    win = 1'b0;
    endcase
    sav = m_sav[0] & ~m_unlock & win;
    case (m_mapper)
      3'd0: r.sram_addr = sav ? 24'hE00000 + (24'({a[20:16], a[12:0]}) & m_sav)
                              : {1'b0, a[22:0]} & m_rom;
      3'd1: r.sram_addr = sav ? 24'hE00000 + (24'({a[20:16], a[14:0]}) & m_sav)
                              : {1'b0, ~a[23], a[22:16], a[14:0]} & m_rom;
      3'd2: r.sram_addr = sav ? 24'hE00000 + (24'({a[20:16], a[12:0]}) & m_sav)
                              : {1'b0, ~a[23], a[21:0]} & m_rom;
      3'd7: r.sram_addr = sav ? a : ({1'b0, a[22:0]} & m_rom) + 24'hC00000;
      default: r.sram_addr = '0;
    endcase
    if (patch) r.sram_addr = a;
    r.is_saveram  = sav;
    r.is_rom      = a[22] | a[15];
    r.is_writable = sav | patch;
    r.rom_hit     = r.is_rom | r.is_writable;
    // Peripheral windows in the system banks
    r.msu     = m_feat[3] && !a[22] && off >= 16'h2000 && off <= 16'h2007;
    r.dma     = (m_feat[7] || m_unlock) && !a[22] && off >= 16'h2020 && off <= 16'h202F;
    r.srtc    = m_feat[2] && !a[22] && off >= 16'h2800 && off <= 16'h2801;
    r.exe     = !a[22] && off == 16'h2C00;
    r.snescmd = !a[22] && off >= 16'h2A00 && off <= 16'h2FFF;
    r.nmicmd  = a == 24'h002BF2;
    r.r213f   = m_feat[4] && pa == 8'h3F;
    r.r2100   = pa == 8'h00;
    r.dspx_a0 = 1'b1;
    if (m_mapper == 3'd1 && m_rom[20]) dwin = a[22] && a[21] && !a[20] && !a[15];
    else if (m_mapper == 3'd1) dwin = !a[22] && a[21] && a[20] && a[15];
    else if (m_mapper == 3'd0) dwin = a[22:20] == 3'b000 && !a[15] && a[14] && a[13];
    r.dspx = m_feat[0] & dwin;
    if (m_feat[0] && m_mapper == 3'd1) r.dspx_a0 = a[14];
    if (m_feat[0] && m_mapper == 3'd0) r.dspx_a0 = a[12];
    return r;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  task automatic write_cfg(input logic [2:0] sel, input logic [23:0] data);
    @(posedge CLK);
    cycle_start <= 1'b0;
    cfg_write   <= 1'b1;
    cfg_sel     <= sel;
    cfg_data    <= data;
    case (sel)
      3'd0: m_mapper = data[2:0];
      3'd1: m_feat   = data[15:0];
      3'd2: m_rom    = data;
      3'd3: m_sav    = data;
      3'd4: m_unlock = data[0];
      default: ;
    endcase
    @(posedge CLK);
    cfg_write <= 1'b0;
  endtask

  task automatic issue(input logic [23:0] a, input logic [7:0] pa, input logic romsel);
    @(posedge CLK);
    cycle_start <= 1'b1; // Back to back until the next write or idle
    snes_addr   <= a;
    snes_pa     <= pa;
    snes_romsel <= romsel;
    u_checks.expect_req(model(a, pa, romsel));
  endtask

  // Biased toward save-RAM and I/O windows
  function automatic logic [23:0] pick_addr();
    logic [23:0] a;
    a = 24'($urandom);
    case ($urandom % 4)
      0: ;
      1: a[22:20] = 3'b111;
      2: begin
        a[22:21] = 2'b01;
        a[15:13] = 3'b011;
      end
      default: begin
        a[22] = 1'b0;
        a[15:0] = 16'h2000 + 16'($urandom % 16'h1000);
      end
    endcase
    return a;
  endfunction

  // Random address forced into one chosen window
  function automatic logic [23:0] window_addr(input int kind);
    logic [23:0] a;
    a = 24'($urandom);
    case (kind)
      0: a[23:22] = 2'b11;    // Patch banks C0-FF
      1: begin                // HiROM and ExHiROM save-RAM
        a[22:21] = 2'b01;
        a[15:13] = 3'b011;
      end
      2: begin                // DMA registers
        a[22] = 1'b0;
        a[15:4] = 12'h202;
      end
      3: begin                // HiROM coprocessor
        a[22:20] = 3'b000;
        a[15:13] = 3'b011;
      end
      4: begin                // LoROM coprocessor in banks 30-3F
        a[22:20] = 3'b011;
        a[15] = 1'b1;
      end
      default: begin          // LoROM coprocessor in banks 60-6F
        a[22:20] = 3'b110;
        a[15] = 1'b0;
      end
    endcase
    return a;
  endfunction

  initial begin
    void'($urandom(32'hdbc56e33));
    rst = 1'b1;
    cfg_write = 1'b0;
    cfg_sel = '0;
    cfg_data = '0;
    cycle_start = 1'b0;
    snes_addr = '0;
    snes_pa = '0;
    snes_romsel = 1'b1;
    repeat (5) @(posedge CLK);
    rst <= 1'b0;
    repeat (3) @(posedge CLK);
    // Menu mapper straight out of reset
    for (int i = 0; i < 20; i++) issue(i[0] ? {4'hF, 20'($urandom)} : 24'($urandom),
                                       8'($urandom), 1'($urandom));
    write_cfg(3'd3, 24'h00_1FFF);
    // Menu save-RAM passthrough once the mask enables it
    for (int i = 0; i < 8; i++) issue({4'hF, 20'($urandom)}, 8'($urandom), 1'($urandom));
    // HiROM, LoROM, ExHiROM with random masks
    for (int m = 0; m < 3; m++) begin
      write_cfg(3'd0, 24'(m));
      for (int r = 0; r < 4; r++) begin
        write_cfg(3'd2, {2'b00, r[0], 21'($urandom)} | 24'h0FFFFF);
        write_cfg(3'd3, 24'($urandom) | 24'(r < 3));
        for (int i = 0; i < 16; i++) issue(pick_addr(), 8'($urandom), 1'($urandom));
      end
    end
    // Patch window over live save-RAM and DMA windows
    write_cfg(3'd3, 24'h00_1FFF);
    write_cfg(3'd4, 24'h1);
    for (int i = 0; i < 18; i++) issue(window_addr(i % 3), 8'($urandom), 1'b0);
    write_cfg(3'd4, 24'h0);
    // Feature gating at each window edge
    for (int r = 0; r < 4; r++) begin
      write_cfg(3'd0, r[0] ? 24'd1 : 24'd0);
      write_cfg(3'd2, r[1] ? 24'hFFFFFF : 24'h0FFFFF);
      write_cfg(3'd1, 24'($urandom));
      for (int i = 0; i < 40; i++) begin
        issue({8'(i < 20 ? 8'h00 : 8'h40), edges[i % 20]},
              (i % 3 == 0) ? 8'h3F : 8'(i % 3 - 1), 1'b1);
      end
    end
    // Coprocessor windows with the feature off, then on
    for (int r = 0; r < 6; r++) begin
      write_cfg(3'd0, (r < 2) ? 24'd0 : 24'd1);
      write_cfg(3'd2, (r < 4) ? 24'h0FFFFF : 24'hFFFFFF);
      write_cfg(3'd1, {8'h00, 15'($urandom), r[0]});
      for (int i = 0; i < 8; i++) issue(window_addr(3 + r / 2), 8'($urandom), 1'($urandom));
    end
    @(posedge CLK);
    cycle_start <= 1'b0;
    while (u_checks.pending() != 0) @(posedge CLK);
    repeat (3) @(posedge CLK);
    $display("Errors: %0d", u_checks.error_count);
    if (u_checks.error_count == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
